// ==== Makefile ====
# Verilator build and run for the arcade IO testbench

VERILATOR ?= verilator
TOP       ?= arcade_io_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SOURCES := $(wildcard design/*.sv tests/*.sv include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Fails unless the pass message appears in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/arcade_io_pkg.sv ====
`default_nettype none

`include "arcade_io_config.svh"

package arcade_io_pkg;

  // ------------------------------
  // Joystick word, two views
  // ------------------------------

  // Named bits, all active low
  typedef struct packed {
    logic reset_n;   // Bit 11
    logic coin_n;    // Bit 10
    logic aux_n;     // Bit 9
    logic start_n;   // Bit 8
    logic spare;     // Bit 7
    logic fire2_n;   // Bit 6
    logic fire3_n;   // Bit 5
    logic fire1_n;   // Bit 4
    logic right_n;   // Bit 3
    logic left_n;    // Bit 2
    logic down_n;    // Bit 1
    logic up_n;      // Bit 0
  } joy_fields_t;

  typedef union packed {
    logic [11:0] raw;  // Loaded bit by bit from the chain
    joy_fields_t f;    // Decoded by the mapper
  } joy_word_u;

  // One cabinet control byte as the core reads it
  typedef struct packed {
    logic coin;
    logic start;
    logic up;
    logic down;
    logic right;
    logic left;
    logic fire;
    logic cabinet;   // Only active-high field
  } cab_ctrl_t;

  // ------------------------------
  // Serial slot map
  // ------------------------------

  typedef struct packed {
    logic [1:0] player;   // 1 or 2
    logic [3:0] bit_idx;  // Bit in the raw view
  } joy_slot_t;

  // Slots 0 and 1 carry no data
  localparam joy_slot_t joy_slot_map [2:`JOY_FRAME_LEN-1] = '{
    '{2'd1, 4'd8},  '{2'd1, 4'd6},  '{2'd1, 4'd5},  '{2'd1, 4'd4},   // Slots 2..5
    '{2'd1, 4'd3},  '{2'd1, 4'd2},  '{2'd1, 4'd1},  '{2'd1, 4'd0},   // Slots 6..9
    '{2'd2, 4'd8},  '{2'd2, 4'd6},  '{2'd2, 4'd5},  '{2'd2, 4'd4},   // Slots 10..13
    '{2'd2, 4'd3},  '{2'd2, 4'd2},  '{2'd2, 4'd1},  '{2'd2, 4'd0},   // Slots 14..17
    '{2'd2, 4'd10}, '{2'd2, 4'd11}, '{2'd2, 4'd9},  '{2'd2, 4'd7},   // Slots 18..21
    '{2'd1, 4'd10}, '{2'd1, 4'd11}, '{2'd1, 4'd9},  '{2'd1, 4'd7}    // Slots 22..25
  };

endpackage

`default_nettype wire

// ==== design/arcade_io_top.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module arcade_io_top (
  input  logic                 ena_x,        // Single system clock
  input  logic                 pll_lckd,     // Async reset, active low
  input  logic                 joy_data,
  input  logic                 btn_reset_n,
  input  logic [20:0]          scan_sw,      // Key states from the keyboard decoder
  input  logic [`DAC_BITS-1:0] snd,          // Core sound sample
  output logic                 joy_clk,
  output logic                 joy_load,
  output logic [7:0]           ctrl1,        // Player 1 control byte
  output logic [7:0]           ctrl2,        // Player 2 control byte
  output logic                 core_rst,
  output logic                 audio_l,
  output logic                 audio_r
);

  import arcade_io_pkg::*;

  joy_word_u p1;            // Reader to mapper
  joy_word_u p2;
  logic      frame_valid;
  cab_ctrl_t ctrl1_s;
  cab_ctrl_t ctrl2_s;
  logic      reset_req;     // Mapper to sequencer
  logic      dac_out;

  // Chain is clocked straight from the system clock
  assign joy_clk = ena_x;

  // ------------------------------
  // Joystick input path
  // ------------------------------

  joy_serial_reader joy_serial_reader_i (
    .ena_x       (ena_x),
    .pll_lckd    (pll_lckd),
    .joy_data    (joy_data),
    .joy_load    (joy_load),
    .p1          (p1),
    .p2          (p2),
    .frame_valid (frame_valid)
  );

  cabinet_ctrl_mapper cabinet_ctrl_mapper_i (
    .ena_x       (ena_x),
    .pll_lckd    (pll_lckd),
    .p1          (p1),
    .p2          (p2),
    .frame_valid (frame_valid),
    .scan_sw     (scan_sw),
    .btn_reset_n (btn_reset_n),
    .ctrl1       (ctrl1_s),
    .ctrl2       (ctrl2_s),
    .reset_req   (reset_req)
  );

  assign ctrl1 = ctrl1_s;   // Flattened for the board pins
  assign ctrl2 = ctrl2_s;

  // ------------------------------
  // Reset and audio
  // ------------------------------

  power_reset_seq power_reset_seq_i (
    .ena_x     (ena_x),
    .pll_lckd  (pll_lckd),
    .reset_req (reset_req),
    .core_rst  (core_rst)
  );

  sigma_delta_dac sigma_delta_dac_i (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .core_rst (core_rst),
    .snd      (snd),
    .dac_out  (dac_out)
  );

  // Mono stream on both channels
  assign audio_l = dac_out;
  assign audio_r = dac_out;

endmodule

`default_nettype wire

// ==== design/cabinet_ctrl_mapper.sv ====
`default_nettype none

module cabinet_ctrl_mapper (
  input  logic                     ena_x,
  input  logic                     pll_lckd,
  input  arcade_io_pkg::joy_word_u p1,
  input  arcade_io_pkg::joy_word_u p2,
  input  logic                     frame_valid,
  input  logic [20:0]              scan_sw,      // Keyboard key states, high = pressed
  input  logic                     btn_reset_n,  // Board button
  output arcade_io_pkg::cab_ctrl_t ctrl1,
  output arcade_io_pkg::cab_ctrl_t ctrl2,
  output logic                     reset_req
);

  import arcade_io_pkg::*;

  localparam int KEY_RESET = 5;

  joy_word_u  p1_q;      // Last complete frame
  joy_word_u  p2_q;
  joy_word_u  p1_nxt;    // Frame used this cycle
  joy_word_u  p2_nxt;
  logic [6:0] ovr1;      // Overrides {coin, start, up, down, right, left, fire}
  logic [6:0] ovr2;

  // ------------------------------
  // Field mapping
  // ------------------------------

  // Pressed key forces the active-low bit low
  function automatic cab_ctrl_t map_ctrl(input joy_word_u w, input logic [6:0] ovr,
                                         input logic cab);
    cab_ctrl_t c;
    c.coin    = w.f.coin_n  & ~ovr[6];
    c.start   = w.f.start_n & ~ovr[5];
    c.up      = w.f.up_n    & ~ovr[4];
    c.down    = w.f.down_n  & ~ovr[3];
    c.right   = w.f.right_n & ~ovr[2];
    c.left    = w.f.left_n  & ~ovr[1];
    c.fire    = w.f.fire1_n & ~ovr[0];
    c.cabinet = cab;
    return c;
  endfunction

  // Key numbers per player
  assign ovr1 = {scan_sw[13], scan_sw[11], scan_sw[0], scan_sw[1],
                 scan_sw[3], scan_sw[2], scan_sw[4]};
  assign ovr2 = {scan_sw[20], scan_sw[12], scan_sw[14], scan_sw[15],
                 scan_sw[17], scan_sw[16], scan_sw[18]};

  // New frame bypasses the latch so it shows one cycle after the strobe
  assign p1_nxt = frame_valid ? p1 : p1_q;
  assign p2_nxt = frame_valid ? p2 : p2_q;

  // ------------------------------
  // Registers
  // ------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      p1_q.raw <= '1;
      p2_q.raw <= '1;
    end else if (frame_valid) begin
      p1_q <= p1;   // Later frame simply replaces earlier one
      p2_q <= p2;
    end
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      ctrl1     <= 8'hFE;   // Released, upright cabinet bit low
      ctrl2     <= 8'hFF;   // Released, cabinet bit high
      reset_req <= 1'b0;
    end else begin
      ctrl1     <= map_ctrl(p1_nxt, ovr1, 1'b0);
      ctrl2     <= map_ctrl(p2_nxt, ovr2, 1'b1);
      reset_req <= scan_sw[KEY_RESET] | ~p1_nxt.f.reset_n | ~btn_reset_n;
    end
  end

endmodule

`default_nettype wire

// ==== design/joy_serial_reader.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module joy_serial_reader (
  input  logic                    ena_x,
  input  logic                    pll_lckd,
  input  logic                    joy_data,     // Serial data from the chain
  output logic                    joy_load,     // Parallel load, low one cycle per frame
  output arcade_io_pkg::joy_word_u p1,
  output arcade_io_pkg::joy_word_u p2,
  output logic                    frame_valid   // Words complete
);

  import arcade_io_pkg::*;

  localparam int CNT_W = $clog2(`JOY_FRAME_LEN);
  localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`JOY_FRAME_LEN - 1);
  localparam logic [CNT_W-1:0] FIRST_DATA = CNT_W'(2);

  logic [CNT_W-1:0] slot_cnt;
  logic [CNT_W-1:0] sample_slot;   // Slot sampled at the coming edge
  logic             slot_valid;
  joy_slot_t        slot_ent;

  // ------------------------------
  // Frame counter and load pulse
  // ------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      slot_cnt <= '0;
      joy_load <= 1'b1;
    end else begin
      joy_load <= (slot_cnt != '0);   // Low in the cycle after slot 0
      if (slot_cnt == LAST_SLOT)
        slot_cnt <= '0;               // Wrap at end of frame
      else
        slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Slot decode
  // ------------------------------

  // Edge k after the load edge samples slot k+1
  assign sample_slot = slot_cnt + 1'b1;
  assign slot_valid  = (sample_slot >= FIRST_DATA) && (sample_slot <= LAST_SLOT);

  always_comb begin
    slot_ent = '0;
    if (slot_valid)
      slot_ent = joy_slot_map[sample_slot];   // Player and bit for this slot
  end

  // ------------------------------
  // Player words
  // ------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      p1.raw <= '1;   // Released
      p2.raw <= '1;
    end else if (slot_valid) begin
      if (slot_ent.player == 2'd1)
        p1.raw[slot_ent.bit_idx] <= joy_data;
      else
        p2.raw[slot_ent.bit_idx] <= joy_data;
    end
  end

  // Strobe follows the slot 25 sample by one cycle
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd)
      frame_valid <= 1'b0;
    else
      frame_valid <= (sample_slot == LAST_SLOT);
  end

endmodule

`default_nettype wire

// ==== design/power_reset_seq.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module power_reset_seq (
  input  logic ena_x,
  input  logic pll_lckd,
  input  logic reset_req,   // From the control mapper
  output logic core_rst     // Game core reset, active high
);

  localparam int DLY_W = $clog2(`RESET_DELAY);
  localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`RESET_DELAY - 1);

  logic [DLY_W-1:0] dly_cnt;
  logic             pwr_hold;   // Power-up delay still running

  // ------------------------------
  // Power-up delay
  // ------------------------------

  assign pwr_hold = (dly_cnt != DLY_LAST);

  // Saturates at the last count
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd)
      dly_cnt <= '0;
    else if (pwr_hold)
      dly_cnt <= dly_cnt + 1'b1;
  end

  // ------------------------------
  // Core reset register
  // ------------------------------

  // Falls on edge RESET_DELAY after release, then tracks the request
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd)
      core_rst <= 1'b1;
    else
      core_rst <= pwr_hold | reset_req;
  end

endmodule

`default_nettype wire

// ==== design/sigma_delta_dac.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module sigma_delta_dac (
  input  logic                 ena_x,
  input  logic                 pll_lckd,
  input  logic                 core_rst,      // Clears the accumulator
  input  logic [`DAC_BITS-1:0] snd,           // Signed sample from the core
  output logic                 dac_out        // One-bit stream
);

  localparam int MSB = `DAC_BITS - 1;

  logic [`DAC_BITS-1:0] offset_val;   // Sample shifted to unsigned
  logic [`DAC_BITS:0]   acc;          // Carry in the top bit

  // Flip the sign bit, zero sample lands at mid scale
  assign offset_val = {~snd[MSB], snd[MSB-1:0]};

  // ------------------------------
  // First-order modulator
  // ------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd)
      acc <= '0;
    else if (core_rst)
      acc <= '0;   // Quiet while the core is held
    else
      acc <= {1'b0, acc[MSB:0]} + {1'b0, offset_val};
  end

  // Carry density is offset_val / 2**DAC_BITS
  assign dac_out = acc[`DAC_BITS];

endmodule

`default_nettype wire

// ==== include/arcade_io_config.svh ====
`ifndef ARCADE_IO_CONFIG_SVH
`define ARCADE_IO_CONFIG_SVH

// ------------------------------
// Joystick shift chain
// ------------------------------

// ena_x cycles per serial frame, slots 0 to 25
`define JOY_FRAME_LEN 26

// ------------------------------
// Reset and audio
// ------------------------------

// Cycles core_rst stays high after pll_lckd release
`define RESET_DELAY 256

// Width of the core sound sample
`define DAC_BITS 8

`endif

// ==== list.f ====
+incdir+include
design/arcade_io_pkg.sv
design/joy_serial_reader.sv
design/cabinet_ctrl_mapper.sv
design/power_reset_seq.sv
design/sigma_delta_dac.sv
design/arcade_io_top.sv
tests/arcade_io_properties.sv
tests/arcade_io_tb.sv

// ==== tests/arcade_io_properties.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module arcade_io_props (
  input logic ena_x,
  input logic pll_lckd,
  input logic joy_load,
  input logic core_rst,
  input logic audio_l,
  input logic audio_r
);

  int   rel_cnt;     // Cycles since pll_lckd release, saturating
  int   high_run;    // joy_load high samples since the last load
  logic seen_load;   // First load pulse has passed

  // ------------------------------
  // Observation counters
  // ------------------------------

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      rel_cnt   <= 0;
      high_run  <= 0;
      seen_load <= 1'b0;
    end else begin
      if (rel_cnt < `RESET_DELAY)
        rel_cnt <= rel_cnt + 1;
      if (!joy_load) begin
        high_run  <= 0;     // New frame starts
        seen_load <= 1'b1;
      end else begin
        high_run <= high_run + 1;
      end
    end
  end

  // ------------------------------
  // Properties
  // ------------------------------

  // Load pulse is a single cycle
  load_one_cycle: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |=> joy_load)
    else $error("joy_load held low for more than one cycle");

  // Frame of 26 cycles, 25 of them high
  load_spacing: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (!joy_load && seen_load) |-> (high_run == `JOY_FRAME_LEN - 1))
    else $error("joy_load high run differs from one frame");

  rst_delay: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (rel_cnt < `RESET_DELAY) |-> core_rst)
    else $error("core_rst dropped during the power-up delay");

  // Both pins quiet while the core is held
  audio_quiet: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    core_rst |=> (!audio_l && !audio_r))
    else $error("audio pins active while core_rst is high");

endmodule

`default_nettype wire

// ==== tests/arcade_io_tb.sv ====
`default_nettype none

`include "arcade_io_config.svh"

module arcade_io_tb;

  import arcade_io_pkg::*;

  localparam int WAIT_LIMIT = 4 * `JOY_FRAME_LEN;   // Cycles allowed per wait loop
  localparam int KEY1 [7] = '{13, 11, 0, 1, 3, 2, 4};      // coin start up down right left fire
  localparam int KEY2 [7] = '{20, 12, 14, 15, 17, 16, 18};
  localparam int JOY_BIT [7] = '{10, 8, 0, 1, 3, 2, 4};    // Joystick field per control bit
  localparam logic [7:0] SAMPLES [5] = '{8'h00, 8'h7F, 8'h80, 8'hC0, 8'h35};

  logic                 ena_x       = 1'b0;
  logic                 pll_lckd    = 1'b0;   // Held in reset from time 0
  logic                 joy_data    = 1'b1;
  logic                 btn_reset_n = 1'b1;
  logic [20:0]          scan_sw     = '0;
  logic [`DAC_BITS-1:0] snd         = '0;
  logic                 joy_clk;
  logic                 joy_load;
  logic [7:0]           ctrl1;
  logic [7:0]           ctrl2;
  logic                 core_rst;
  logic                 audio_l;
  logic                 audio_r;

  int          errors;
  int          checks;
  int          seed;
  int          chain_pos = 0;     // Slot presented for the coming edge
  logic [11:0] chain_p1  = '1;    // Words held in the external chain
  logic [11:0] chain_p2  = '1;

  arcade_io_top arcade_io_top_i (.*);

  bind arcade_io_top arcade_io_props arcade_io_props_i (.*);

  always #20 ena_x = ~ena_x;

  // ------------------------------
  // Shift-chain model
  // ------------------------------

  function automatic logic slot_bit(input int pos, input logic [11:0] w1, input logic [11:0] w2);
    joy_slot_t ent;
    if (pos < 2 || pos > `JOY_FRAME_LEN - 1)
      return 1'b1;   // Filler slots idle high
    ent = joy_slot_map[pos];
    return (ent.player == 2'd1) ? w1[ent.bit_idx] : w2[ent.bit_idx];
  endfunction

  always @(negedge ena_x) begin
    if (!joy_load)
      chain_pos = 2;   // Load seen, first data slot next
    else if (chain_pos >= 2 && chain_pos < `JOY_FRAME_LEN - 1)
      chain_pos = chain_pos + 1;
    else
      chain_pos = 0;
    joy_data = slot_bit(chain_pos, chain_p1, chain_p2);
  end

  // ------------------------------
  // Expected values and helpers
  // ------------------------------

  // Control byte from the field rules, keys force bits low
  function automatic logic [7:0] expected_ctrl(input logic [11:0] w, input logic [20:0] keys,
                                               input int player);
    logic [7:0] c;
    int         key;
    c[0] = (player == 2);   // Cabinet bit
    for (int i = 0; i < 7; i++) begin
      key = (player == 1) ? KEY1[i] : KEY2[i];
      c[7 - i] = w[JOY_BIT[i]] & ~keys[key];
    end
    return c;
  endfunction

  task automatic report_mismatch(input string test, input int expected, input int actual);
    errors++;
    $display("FAILED %s expected 0x%0h actual 0x%0h", test, expected, actual);
  endtask

  task automatic wait_load(input string test);
    int n;
    n = 0;
    @(negedge ena_x);   // Step past a pulse already showing
    while (joy_load && n < WAIT_LIMIT) begin
      @(negedge ena_x);
      n++;
    end
    if (joy_load) begin
      errors++;
      $display("%s: joy_load pulse did not arrive in time", test);
    end
  endtask

  // Two loads, so one whole frame carries the new words
  task automatic load_chain(input logic [11:0] w1, input logic [11:0] w2, input string test);
    chain_p1 = w1;
    chain_p2 = w2;
    wait_load(test);
    wait_load(test);
  endtask

  task automatic wait_core_rst(input logic level, input string test);
    int n;
    n = 0;
    while (core_rst !== level && n < WAIT_LIMIT) begin
      @(negedge ena_x);
      n++;
    end
    checks++;
    if (core_rst !== level) begin
      errors++;
      $display("%s: core_rst did not reach %b in time", test, level);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic power_up_reset();
    int high_cycles;
    high_cycles = 0;
    // Count starts on the release edge itself
    while (core_rst && high_cycles < `RESET_DELAY + WAIT_LIMIT) begin
      high_cycles++;
      @(negedge ena_x);
    end
    checks += 3;
    if (core_rst) begin
      errors++;
      $display("power_up: core_rst was never released");
    end else if (high_cycles != `RESET_DELAY)
      report_mismatch("power_up core_rst cycles", `RESET_DELAY, high_cycles);
    if (ctrl1 !== 8'hFE)
      report_mismatch("power_up ctrl1", 32'hFE, int'(ctrl1));
    if (ctrl2 !== 8'hFF)
      report_mismatch("power_up ctrl2", 32'hFF, int'(ctrl2));
  endtask

  // Chain clock copies the system clock, probed a quarter period into each phase
  task automatic joy_clk_check();
    for (int i = 0; i < 4; i++) begin
      #10;
      checks++;
      if (joy_clk !== 1'b0)
        report_mismatch("joy_clk low phase", 0, int'(joy_clk));
      #20;
      checks++;
      if (joy_clk !== 1'b1)
        report_mismatch("joy_clk high phase", 1, int'(joy_clk));
      @(negedge ena_x);
    end
  endtask

  task automatic joystick_decode();
    int          rnd;
    logic [11:0] w1;
    logic [11:0] w2;
    for (int r = 0; r < 4; r++) begin
      rnd = $random(seed);
      w1 = rnd[11:0] | 12'h800;   // Player 1 reset_n stays released
      rnd = $random(seed);
      w2 = rnd[11:0];
      load_chain(w1, w2, "joy_decode");
      checks += 2;
      if (ctrl1 !== expected_ctrl(w1, 21'd0, 1))
        report_mismatch("joy_decode ctrl1", int'(expected_ctrl(w1, 21'd0, 1)), int'(ctrl1));
      if (ctrl2 !== expected_ctrl(w2, 21'd0, 2))
        report_mismatch("joy_decode ctrl2", int'(expected_ctrl(w2, 21'd0, 2)), int'(ctrl2));
    end
    load_chain(12'hFFF, 12'hFFF, "joy_decode");   // Back to released
  endtask

  task automatic key_overrides();
    logic [20:0] keys;
    for (int k = 0; k < 21; k++) begin
      if (k == 5)
        continue;            // Reset key, covered below
      keys = 21'd1 << k;
      scan_sw = keys;
      @(negedge ena_x);      // One registered stage
      checks += 2;
      if (ctrl1 !== expected_ctrl(12'hFFF, keys, 1))
        report_mismatch($sformatf("key_override key %0d ctrl1", k),
                        int'(expected_ctrl(12'hFFF, keys, 1)), int'(ctrl1));
      if (ctrl2 !== expected_ctrl(12'hFFF, keys, 2))
        report_mismatch($sformatf("key_override key %0d ctrl2", k),
                        int'(expected_ctrl(12'hFFF, keys, 2)), int'(ctrl2));
    end
    scan_sw = '0;
    @(negedge ena_x);
  endtask

  task automatic reset_requests();
    scan_sw[5] = 1'b1;
    wait_core_rst(1'b1, "reset_request key 5");
    scan_sw[5] = 1'b0;
    wait_core_rst(1'b0, "reset_request key 5 release");
    load_chain(12'h7FF, 12'hFFF, "reset_request");   // p1 reset_n low
    wait_core_rst(1'b1, "reset_request p1 reset_n");
    load_chain(12'hFFF, 12'hFFF, "reset_request");
    wait_core_rst(1'b0, "reset_request p1 reset_n release");
    btn_reset_n = 1'b0;
    wait_core_rst(1'b1, "reset_request button");
    btn_reset_n = 1'b1;
    wait_core_rst(1'b0, "reset_request button release");
  endtask

  task automatic dac_density();
    int ones_l;
    int ones_r;
    int expected;
    for (int s = 0; s < 5; s++) begin
      snd = SAMPLES[s];
      @(negedge ena_x);   // New sample reaches the accumulator
      ones_l = 0;
      ones_r = 0;
      for (int c = 0; c < 2 ** `DAC_BITS; c++) begin
        if (audio_l)
          ones_l++;
        if (audio_r)
          ones_r++;
        @(negedge ena_x);
      end
      expected = int'(SAMPLES[s] ^ 8'h80);   // Offset value, top bit flipped
      checks += 2;
      if (ones_l < expected - 1 || ones_l > expected + 1)
        report_mismatch($sformatf("dac_density audio_l snd %0h", SAMPLES[s]),
                        expected, ones_l);
      if (ones_r < expected - 1 || ones_r > expected + 1)
        report_mismatch($sformatf("dac_density audio_r snd %0h", SAMPLES[s]),
                        expected, ones_r);
    end
  endtask

  // ------------------------------
  // Sequence and report
  // ------------------------------

  initial begin
    errors = 0;
    checks = 0;
    seed   = 36;
    repeat (2) @(negedge ena_x);
    pll_lckd = 1'b1;   // Release on a falling edge
    power_up_reset();
    joy_clk_check();
    joystick_decode();
    key_overrides();
    reset_requests();
    dac_density();
    $display("Closing report: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
